//--- common/conv_pkg.sv
package conv_pkg;

	localparam int LANES   = 8;                  // Output channels computed in parallel.
	localparam int CHIN    = 4;                  // Input channels per window.
	localparam int KDIM    = 3;                  // Kernel side.
	localparam int WIN_LEN = KDIM * KDIM * CHIN; // Products per window.
	localparam int WOUT    = 4;                  // Output map side.
	localparam int NWIN    = WOUT * WOUT;        // Windows per layer run.
	localparam int PIX_W   = 16;                 // Feature and weight word width.
	localparam int FRAC    = 14;                 // Q2.14 fraction bits.
	localparam int ACC_W   = 33;                 // Window sum in Q.28 with headroom.
	localparam int POS_W   = $clog2(WIN_LEN);    // Window position counter width.
	localparam int WCNT_W  = $clog2(NWIN) + 1;   // Window counter reaches NWIN.

	typedef logic signed [PIX_W-1:0] pix_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	typedef pix_t [LANES-1:0] pix_vec_t;
	typedef acc_t [LANES-1:0] acc_vec_t;

	// One pipeline item. first and last mark the window boundaries,
	// so back-to-back windows need no separate clear.
	typedef struct packed {
		logic valid;
		logic first; // First product of a window.
		logic last;  // Last product of a window.
		pix_t pix;
	} stream_t;

	// Weight rule shared by the coefficient ROM and the testbench model.
	// Values span -8..8 times 1024, so both signs appear across lanes.
	function automatic pix_t weight_of(input int lane, input int pos);
		int step;
		step = (lane * 7 + pos * 3) % 17 - 8;
		return pix_t'(step * 1024);
	endfunction

	// Bias per lane in Q.28 (lane-3)/64.
	function automatic acc_t bias_of(input int lane);
		int b;
		b = (lane - 3) * (1 << 22);
		return acc_t'(b);
	endfunction

	// Output rule, used by the RTL output stage and the testbench model.
	// Let s be the window sum of products plus the lane bias.
	// A negative s gives 0 (ReLU).
	// Otherwise the output is a zero sign bit followed by s[28:14],
	// which rescales Q.28 back to Q2.14 with no saturation.

endpackage

//--- expand3_layer/coef_rom.sv
`timescale 1ns/10ps

module coef_rom (
	input  logic [conv_pkg::POS_W-1:0] addr,
	output conv_pkg::pix_vec_t         weights,
	output conv_pkg::acc_vec_t         biases
);

	typedef conv_pkg::pix_vec_t [conv_pkg::WIN_LEN-1:0] wtab_t;

	function automatic wtab_t build_wtab();
		wtab_t t;
		for (int p = 0; p < conv_pkg::WIN_LEN; p++) begin
			for (int l = 0; l < conv_pkg::LANES; l++) begin
				t[p][l] = conv_pkg::weight_of(l, p);
			end
		end
		return t;
	endfunction

	function automatic conv_pkg::acc_vec_t build_bias();
		conv_pkg::acc_vec_t b;
		for (int l = 0; l < conv_pkg::LANES; l++) begin
			b[l] = conv_pkg::bias_of(l);
		end
		return b;
	endfunction

	// Tables are fixed at elaboration and map onto constant memories.
	localparam wtab_t              WTAB = build_wtab();
	localparam conv_pkg::acc_vec_t BTAB = build_bias();

	always_comb begin
		if (addr < conv_pkg::POS_W'(conv_pkg::WIN_LEN)) begin
			weights = WTAB[addr];
		end else begin
			weights = '0; // Unused positions read as zero.
		end
	end

	assign biases = BTAB;

endmodule

//--- expand3_layer/expand3_layer.sv
`timescale 1ns/10ps

module expand3_layer (
	input  logic               clk,
	input  logic               rst,
	input  logic               en,
	input  conv_pkg::pix_t     ifm,
	input  logic               ram_busy,
	output logic               sample,
	output conv_pkg::pix_vec_t ofm,
	output logic               finish
);

	logic                        accept;
	logic                        done;
	logic [conv_pkg::POS_W-1:0]  pos;
	logic [conv_pkg::WCNT_W-1:0] win_cnt;

	conv_pkg::pix_vec_t          rom_w;
	conv_pkg::acc_vec_t          rom_b;

	conv_pkg::stream_t           s1_item;
	conv_pkg::pix_vec_t          s1_ker;

	conv_pkg::acc_vec_t          lane_acc;
	logic [conv_pkg::LANES-1:0]  lane_valid;
	logic                        win_done;
	conv_pkg::acc_vec_t          sum;

	assign accept = en && !done; // Input is ignored once the layer is done.

	// Window position sequencer, also the ROM address.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pos <= '0;
		end else if (accept) begin
			if (pos == conv_pkg::POS_W'(conv_pkg::WIN_LEN - 1)) begin
				pos <= '0;
			end else begin
				pos <= pos + 1'b1;
			end
		end
	end

	coef_rom u_coef_rom (
		.addr    (pos),
		.weights (rom_w),
		.biases  (rom_b)
	);

	// Stage 1 item. An idle cycle leaves an invalid item that lanes skip.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			s1_item <= '0;
		end else begin
			s1_item.valid <= accept;
			s1_item.first <= pos == '0;
			s1_item.last  <= pos == conv_pkg::POS_W'(conv_pkg::WIN_LEN - 1);
			s1_item.pix   <= ifm;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			s1_ker <= rom_w; // Weights for this position, all lanes.
		end
	end

	for (genvar l = 0; l < conv_pkg::LANES; l++) begin : g_lane
		mac_lane u_mac_lane (
			.clk       (clk),
			.rst       (rst),
			.item      (s1_item),
			.ker       (s1_ker[l]),
			.acc       (lane_acc[l]),
			.acc_valid (lane_valid[l])
		);
	end

	assign win_done = &lane_valid; // All lanes close a window together.

	always_comb begin
		for (int l = 0; l < conv_pkg::LANES; l++) begin
			sum[l] = lane_acc[l] + rom_b[l];
		end
	end

	// Output stage with ReLU and rescale from Q.28 to Q2.14.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ofm    <= '0;
			sample <= 1'b0;
		end else begin
			sample <= win_done;
			if (win_done) begin
				for (int l = 0; l < conv_pkg::LANES; l++) begin
					if (sum[l][conv_pkg::ACC_W-1]) begin
						ofm[l] <= '0;
					end else begin
						ofm[l] <= {1'b0, sum[l][2*conv_pkg::FRAC:conv_pkg::FRAC]};
					end
				end
			end
		end
	end

	// Layer end after the last output window.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_cnt <= '0;
			done    <= 1'b0;
		end else if (win_done && !done) begin
			win_cnt <= win_cnt + 1'b1;
			if (win_cnt == conv_pkg::WCNT_W'(conv_pkg::NWIN - 1)) begin
				done <= 1'b1;
			end
		end
	end

	assign finish = done && !ram_busy; // Held back while the feature RAM is busy.

endmodule

//--- expand3_layer/mac_lane.sv
`timescale 1ns/10ps

module mac_lane (
	input  logic              clk,
	input  logic              rst,
	input  conv_pkg::stream_t item,
	input  conv_pkg::pix_t    ker,
	output conv_pkg::acc_t    acc,
	output logic              acc_valid
);

	logic signed [2*conv_pkg::PIX_W-1:0] prod; // Q.28 product.
	conv_pkg::acc_t                      prod_ext;

	assign prod     = item.pix * ker;
	assign prod_ext = conv_pkg::acc_t'(prod); // Sign extend to accumulator width.

	// Running window sum of products.
	always_ff @(posedge clk) begin
		if (item.valid) begin
			if (item.first) begin
				acc <= prod_ext;       // Start a new window.
			end else begin
				acc <= acc + prod_ext;
			end
		end
	end

	// Window is complete one cycle after its last product.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc_valid <= 1'b0;
		end else begin
			acc_valid <= item.valid && item.last;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fire expand testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f src.f \
	--top-module tb_fire_expand \
	-Mdir obj_dir \
	-o sim_fire_expand
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_fire_expand)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- src.f
common/conv_pkg.sv
expand3_layer/mac_lane.sv
expand3_layer/coef_rom.sv
expand3_layer/expand3_layer.sv
src/fire_expand_top.sv
tb/clk_gen.sv
tb/tb_fire_expand.sv

//--- src/fire_expand_top.sv
`timescale 1ns/10ps

module fire_expand_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               en,
	input  conv_pkg::pix_t     ifm,
	input  logic               ram_busy,
	output logic               sample,
	output conv_pkg::pix_vec_t ofm,
	output logic               finish
);

	// Subsystem boundary around the expand 3x3 layer.
	expand3_layer u_expand3_layer (
		.clk      (clk),
		.rst      (rst),
		.en       (en),
		.ifm      (ifm),
		.ram_busy (ram_busy),
		.sample   (sample),
		.ofm      (ofm),
		.finish   (finish)
	);

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
	parameter int HALF       = 4, // Half of the 8 ns period.
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HALF) clk = ~clk;
	end

	initial begin
		rst = 1'b0;                    // Active low, held for RST_CYCLES edges.
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

//--- tb/tb_fire_expand.sv
`timescale 1ns/10ps

module tb_fire_expand;

	localparam int STIM_CYCLES = 10 + conv_pkg::NWIN * conv_pkg::WIN_LEN * 4 + 40 + 40;
	localparam int TIMEOUT_NS  = (STIM_CYCLES + 200) * 8;

	logic               clk;
	logic               rst;
	logic               en;
	conv_pkg::pix_t     ifm;
	logic               ram_busy;
	logic               sample;
	conv_pkg::pix_vec_t ofm;
	logic               finish;

	// Reference model state.
	conv_pkg::pix_t             win_words [conv_pkg::WIN_LEN];
	conv_pkg::pix_vec_t         exp_q [$];
	logic [conv_pkg::LANES-1:0] neg_q [$];
	int                         model_pos = 0;
	int                         model_wins = 0;
	logic                       model_done = 1'b0;
	logic [2:0]                 last_pipe = '0;   // Accepted last word, delayed to sample time.
	int                         n_samples = 0;
	int                         neg_cases = 0;
	int                         busy_hold_cycles = 0;
	logic                       finish_seen = 1'b0;
	int                         value_errs = 0;
	int                         proto_errs = 0;
	int                         end_errs = 0;
	logic [31:0]                rng_state = 32'd54;

	clk_gen u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	fire_expand_top uut (
		.clk      (clk),
		.rst      (rst),
		.en       (en),
		.ifm      (ifm),
		.ram_busy (ram_busy),
		.sample   (sample),
		.ofm      (ofm),
		.finish   (finish)
	);

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 8;
	endfunction

	// Pixel in -1.0 .. +1.0 of Q2.14.
	function automatic conv_pkg::pix_t rand_pix();
		logic [31:0] r;
		r = next_rand();
		return conv_pkg::pix_t'(int'(r % 32'd32769) - 16384);
	endfunction

	function automatic conv_pkg::acc_t window_sum(input int lane);
		longint s;
		s = 0;
		for (int p = 0; p < conv_pkg::WIN_LEN; p++) begin
			s += longint'(win_words[p]) * longint'(conv_pkg::weight_of(lane, p));
		end
		s += longint'(conv_pkg::bias_of(lane));
		return conv_pkg::acc_t'(s); // Accumulator wraps at its width.
	endfunction

	function automatic conv_pkg::pix_t relu_rescale(input conv_pkg::acc_t s);
		if (s < 0) begin
			return '0;
		end
		return {1'b0, s[2*conv_pkg::FRAC:conv_pkg::FRAC]};
	endfunction

	task automatic push_expected();
		conv_pkg::pix_vec_t         v;
		logic [conv_pkg::LANES-1:0] neg;
		conv_pkg::acc_t             s;
		for (int l = 0; l < conv_pkg::LANES; l++) begin
			s      = window_sum(l);
			v[l]   = relu_rescale(s);
			neg[l] = s < 0;
			if (s < 0) begin
				neg_cases++;
			end
		end
		exp_q.push_back(v);
		neg_q.push_back(neg);
	endtask

	task automatic check_window(input conv_pkg::pix_vec_t exp_v, input logic [7:0] neg);
		for (int l = 0; l < conv_pkg::LANES; l++) begin
			assert (ofm[l] == exp_v[l]) else begin
				value_errs++;
				$display("ERROR %0t: window %0d lane %0d ofm=%h expected %h",
					$time, n_samples, l, ofm[l], exp_v[l]);
			end
			if (neg[l]) begin
				assert (ofm[l] == '0) else begin
					value_errs++;
					$display("ERROR %0t: window %0d lane %0d negative sum not zero",
						$time, n_samples, l);
				end
			end
		end
	endtask

	task automatic drive_word(input conv_pkg::pix_t px);
		@(posedge clk);
		en  <= 1'b1;
		ifm <= px;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			en <= 1'b0;
		end
	endtask

	// Monitor and model, on pre-edge values.
	always @(posedge clk) begin
		logic took_last;
		took_last = 1'b0;
		if (rst) begin
			if (n_samples == 0 && !sample) begin
				assert (!finish && ofm == '0) else begin
					proto_errs++;
					$display("ERROR %0t: outputs active before the first window", $time);
				end
			end
			if (sample) begin
				if (exp_q.size() == 0) begin
					proto_errs++;
					$display("Sample pulse at %0t with no window pending", $time);
				end else begin
					check_window(exp_q.pop_front(), neg_q.pop_front());
				end
				n_samples++;
			end
			if (en && !model_done) begin
				win_words[model_pos] = ifm;
				if (model_pos == conv_pkg::WIN_LEN - 1) begin
					push_expected();
					model_wins++;
					model_pos = 0;
					took_last = 1'b1;
				end else begin
					model_pos++;
				end
			end
			last_pipe <= {last_pipe[1:0], took_last};
			if (last_pipe[1] && model_wins == conv_pkg::NWIN) begin
				model_done <= 1'b1;
			end
			if (finish) begin
				finish_seen = 1'b1;
			end
			if (model_done && ram_busy) begin
				busy_hold_cycles++;
			end
		end
	end

	sample_timing: assert property (@(posedge clk) disable iff (!rst) sample == last_pipe[2])
		else begin
			proto_errs++;
			$display("ERROR %0t: sample not 2 cycles after a window's last word", $time);
		end

	single_pulse: assert property (@(posedge clk) disable iff (!rst) sample |=> !sample)
		else begin
			proto_errs++;
			$display("ERROR %0t: sample longer than one cycle", $time);
		end

	finish_rule: assert property (@(posedge clk) disable iff (!rst)
		finish == (model_done && !ram_busy))
		else begin
			proto_errs++;
			$display("ERROR %0t: finish=%b with done=%b ram_busy=%b",
				$time, finish, model_done, ram_busy);
		end

	initial begin
		int g;
		en       = 1'b0;
		ifm      = '0;
		ram_busy = 1'b0;
		@(posedge rst);
		idle(5);
		for (int w = 0; w < conv_pkg::NWIN; w++) begin
			for (int p = 0; p < conv_pkg::WIN_LEN; p++) begin
				if (w >= conv_pkg::NWIN / 2) begin
					g = int'(next_rand() % 32'd6);
					if (g > 3) begin
						g = 0;
					end
					idle(g);
				end
				drive_word(rand_pix());
				if (w == 12 && p == 0) begin
					ram_busy <= 1'b1; // Feature RAM busy across the layer end.
				end
			end
		end
		repeat (40) drive_word(rand_pix());
		idle(20);
		@(posedge clk);
		en       <= 1'b0;
		ram_busy <= 1'b0;
		idle(10);

		assert (n_samples == conv_pkg::NWIN) else begin
			end_errs++;
			$display("Expected %0d sample pulses but saw %0d", conv_pkg::NWIN, n_samples);
		end
		assert (exp_q.size() == 0) else begin
			end_errs++;
			$display("%0d windows never produced a sample", exp_q.size());
		end
		assert (neg_cases > 0) else begin
			end_errs++;
			$display("No lane had a negative window sum");
		end
		assert (busy_hold_cycles > 0 && finish_seen) else begin
			end_errs++;
			$display("Finish was never held by ram_busy and then released");
		end

		$display("Errors: value %0d, protocol %0d, end of run %0d",
			value_errs, proto_errs, end_errs);
		if (value_errs + proto_errs + end_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the layer did not complete in %0d ns", TIMEOUT_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
